//--- list.f
src/beam_pkg.sv
src/channel_weighter.sv
src/beam_combiner.sv
src/pipe_control.sv
src/beam_sum_top.sv
tests/beam_sum_checker.sv
tests/beam_sum_tb.sv

//--- run.sh
#!/bin/sh
# builds the beam_sum testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module beam_sum_tb -o beam_sum_sim \
    && ./obj_dir/beam_sum_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src/beam_combiner.sv
//********************
// beam_combiner: lane by lane average of all
// weighted channels, registered as stage 2
//********************
`timescale 1ns/1ns
`default_nettype none

module beam_combiner
    import beam_pkg::*;
#(
    parameter int lanes = DEFAULT_LANES
) (
    input  logic  clock,
    input  logic  resetn,
    input  logic  advance,
    input  beat_t real_in [NUM_CHANNELS],
    input  beat_t imag_in [NUM_CHANNELS],
    output beat_t real_out,
    output beat_t imag_out
);

    // running lane sums, two bits wider than a sample so four bytes fit
    logic signed [SUM_WIDTH-1:0] sum_re;
    logic signed [SUM_WIDTH-1:0] sum_im;

    // averaged words that stage 2 takes on advance
    beat_t real_next;
    beat_t imag_next;

    always_comb begin
        real_next = '0;
        imag_next = '0;
        sum_re = '0;
        sum_im = '0;
        for (int l = 0; l < lanes; l++) begin
            sum_re = '0;
            sum_im = '0;

            // the cast makes each byte signed, so it is sign extended in the sum
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                sum_re = sum_re + sample_t'(real_in[c][l*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
                sum_im = sum_im + sample_t'(imag_in[c][l*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
            end

            // add half an LSB, then divide by the channel count
            sum_re = (sum_re + SUM_ROUND) >>> SUM_SHIFT;
            sum_im = (sum_im + SUM_ROUND) >>> SUM_SHIFT;

            // an average of bytes is again a byte, so no clamp is needed here
            real_next[l*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sum_re[SAMPLE_WIDTH-1:0];
            imag_next[l*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sum_im[SAMPLE_WIDTH-1:0];
        end
    end

    // stage 2 register, this drives the output stream directly
    // it holds while the sink stalls because advance is low then
    always_ff @(posedge clock) begin
        if (!resetn) begin
            real_out <= '0;
            imag_out <= '0;
        end else if (advance) begin
            real_out <= real_next;
            imag_out <= imag_next;
        end
    end

endmodule

`default_nettype wire

//--- src/beam_pkg.sv
//********************
// shared widths, lane count, rounding constants
// and the sample, weight and beat types
//********************
`default_nettype none

package beam_pkg;

    // number of antenna channels that are summed into one beam
    parameter int NUM_CHANNELS = 4;

    // every real or imag sample is a signed byte
    parameter int SAMPLE_WIDTH = 8;

    // weights are signed Q1.7, one part for real and one for imag
    parameter int WEIGHT_WIDTH = 8;
    parameter int WEIGHT_FRAC = 7;

    // the average over all channels is a shift by log2 of the channel count
    parameter int SUM_SHIFT = $clog2(NUM_CHANNELS);

    // samples carried side by side in one stream beat
    parameter int DEFAULT_LANES = 16;

    // a complex product needs one bit more than a single product,
    // because two full-scale products can add up
    parameter int PROD_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH + 1;

    // four bytes summed need two guard bits
    parameter int SUM_WIDTH = SAMPLE_WIDTH + SUM_SHIFT;

    // half of one LSB after each shift, so that results round to nearest
    parameter logic signed [PROD_WIDTH-1:0] PROD_ROUND = PROD_WIDTH'(1) <<< (WEIGHT_FRAC - 1);
    parameter logic signed [SUM_WIDTH-1:0] SUM_ROUND = SUM_WIDTH'(1) <<< (SUM_SHIFT - 1);

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // lane 0 sits in the low byte of the word
    typedef logic [DEFAULT_LANES*SAMPLE_WIDTH-1:0] beat_t;

    // saturation bounds of a sample
    parameter sample_t SAMPLE_MAX = 8'sd127;
    parameter sample_t SAMPLE_MIN = -8'sd128;

endpackage

`default_nettype wire

//--- src/beam_sum_top.sv
//********************
// beam_sum_top: four channel weighters, the
// lane combiner and the pipeline control
//********************
`timescale 1ns/1ns
`default_nettype none

module beam_sum_top
    import beam_pkg::*;
#(
    parameter int lanes = DEFAULT_LANES
) (
    input  logic    clock,
    input  logic    resetn,

    // channel 0, its last marks the end of a packet on the output
    input  logic    s_valid_0,
    input  beat_t   s_real_0,
    input  beat_t   s_imag_0,
    input  logic    s_last_0,
    input  weight_t weight_real_0,
    input  weight_t weight_imag_0,

    // channels 1 to 3, their last flags are not looked at
    input  logic    s_valid_1,
    input  beat_t   s_real_1,
    input  beat_t   s_imag_1,
    input  logic    s_last_1,
    input  weight_t weight_real_1,
    input  weight_t weight_imag_1,

    input  logic    s_valid_2,
    input  beat_t   s_real_2,
    input  beat_t   s_imag_2,
    input  logic    s_last_2,
    input  weight_t weight_real_2,
    input  weight_t weight_imag_2,

    input  logic    s_valid_3,
    input  beat_t   s_real_3,
    input  beat_t   s_imag_3,
    input  logic    s_last_3,
    input  weight_t weight_real_3,
    input  weight_t weight_imag_3,

    // one ready for all channels, since they are consumed together
    output logic    s_ready,

    // summed beam
    output logic    m_valid,
    output beat_t   m_real,
    output beat_t   m_imag,
    output logic    m_last,
    input  logic    m_ready
);

    // stage 1 words, one per channel
    beat_t w_real [NUM_CHANNELS];
    beat_t w_imag [NUM_CHANNELS];

    // common enable of both register stages
    logic advance;

    // a lane count beyond the beat word would index past its top
    if (lanes < 1 || lanes > DEFAULT_LANES) begin : g_lanes_check
        $error("lanes must lie between 1 and %0d", DEFAULT_LANES);
    end

    channel_weighter #(.lanes(lanes)) u_weighter_0 (
        .clock(clock), .resetn(resetn), .advance(advance),
        .real_in(s_real_0), .imag_in(s_imag_0),
        .weight_real(weight_real_0), .weight_imag(weight_imag_0),
        .real_out(w_real[0]), .imag_out(w_imag[0])
    );

    channel_weighter #(.lanes(lanes)) u_weighter_1 (
        .clock(clock), .resetn(resetn), .advance(advance),
        .real_in(s_real_1), .imag_in(s_imag_1),
        .weight_real(weight_real_1), .weight_imag(weight_imag_1),
        .real_out(w_real[1]), .imag_out(w_imag[1])
    );

    channel_weighter #(.lanes(lanes)) u_weighter_2 (
        .clock(clock), .resetn(resetn), .advance(advance),
        .real_in(s_real_2), .imag_in(s_imag_2),
        .weight_real(weight_real_2), .weight_imag(weight_imag_2),
        .real_out(w_real[2]), .imag_out(w_imag[2])
    );

    channel_weighter #(.lanes(lanes)) u_weighter_3 (
        .clock(clock), .resetn(resetn), .advance(advance),
        .real_in(s_real_3), .imag_in(s_imag_3),
        .weight_real(weight_real_3), .weight_imag(weight_imag_3),
        .real_out(w_real[3]), .imag_out(w_imag[3])
    );

    beam_combiner #(.lanes(lanes)) u_combiner (
        .clock(clock), .resetn(resetn), .advance(advance),
        .real_in(w_real), .imag_in(w_imag),
        .real_out(m_real), .imag_out(m_imag)
    );

    // only channel 0 carries last, the other three are ignored
    pipe_control u_control (
        .clock(clock), .resetn(resetn),
        .in_valid({s_valid_3, s_valid_2, s_valid_1, s_valid_0}),
        .in_last(s_last_0), .out_ready(m_ready),
        .in_ready(s_ready), .advance(advance),
        .out_valid(m_valid), .out_last(m_last)
    );

endmodule

`default_nettype wire

//--- src/channel_weighter.sv
//********************
// complex weighting of all lanes of one channel
// with rounding, saturation and a register stage
//********************
`timescale 1ns/1ns
`default_nettype none

module channel_weighter
    import beam_pkg::*;
#(
    parameter int lanes = DEFAULT_LANES
) (
    input  logic    clock,
    input  logic    resetn,
    input  logic    advance,
    input  beat_t   real_in,
    input  beat_t   imag_in,
    input  weight_t weight_real,
    input  weight_t weight_imag,
    output beat_t   real_out,
    output beat_t   imag_out
);

    // current lane, split into its real and imag sample
    sample_t s_re;
    sample_t s_im;

    // complex product with the rounding half already added
    logic signed [PROD_WIDTH-1:0] acc_re;
    logic signed [PROD_WIDTH-1:0] acc_im;

    // product scaled back to sample range but still wider than a sample
    logic signed [PROD_WIDTH-1:0] rnd_re;
    logic signed [PROD_WIDTH-1:0] rnd_im;

    // weighted words that stage 1 takes on advance
    beat_t real_next;
    beat_t imag_next;

    // clamps a scaled product into the signed byte range
    function automatic sample_t saturate(input logic signed [PROD_WIDTH-1:0] value);
        sample_t result;
        if (value > SAMPLE_MAX) begin
            result = SAMPLE_MAX;
        end else if (value < SAMPLE_MIN) begin
            result = SAMPLE_MIN;
        end else begin
            result = value[SAMPLE_WIDTH-1:0];
        end
        return result;
    endfunction

    always_comb begin
        // lanes above the configured count stay at zero
        real_next = '0;
        imag_next = '0;
        s_re = '0;
        s_im = '0;
        acc_re = '0;
        acc_im = '0;
        rnd_re = '0;
        rnd_im = '0;
        for (int l = 0; l < lanes; l++) begin
            s_re = real_in[l*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            s_im = imag_in[l*SAMPLE_WIDTH +: SAMPLE_WIDTH];

            // (wr + j wi)(sr + j si) = (wr sr - wi si) + j (wr si + wi sr)
            acc_re = weight_real * s_re - weight_imag * s_im + PROD_ROUND;
            acc_im = weight_real * s_im + weight_imag * s_re + PROD_ROUND;

            // drop the Q1.7 fraction bits and round to the nearest value
            rnd_re = acc_re >>> WEIGHT_FRAC;
            rnd_im = acc_im >>> WEIGHT_FRAC;

            // two large products of the same sign add up to nearly twice the byte range
            real_next[l*SAMPLE_WIDTH +: SAMPLE_WIDTH] = saturate(rnd_re);
            imag_next[l*SAMPLE_WIDTH +: SAMPLE_WIDTH] = saturate(rnd_im);
        end
    end

    // stage 1 register
    // a bubble loads whatever sits on the inputs, and the valid bit in
    // pipe_control marks it as empty
    always_ff @(posedge clock) begin
        if (!resetn) begin
            real_out <= '0;
            imag_out <= '0;
        end else if (advance) begin
            real_out <= real_next;
            imag_out <= imag_next;
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_control.sv
//********************
// pipe_control: valid and last of both stages,
// stall decision and shared input ready
//********************
`timescale 1ns/1ns
`default_nettype none

module pipe_control
    import beam_pkg::*;
(
    input  logic                    clock,
    input  logic                    resetn,
    input  logic [NUM_CHANNELS-1:0] in_valid,
    input  logic                    in_last,
    input  logic                    out_ready,
    output logic                    in_ready,
    output logic                    advance,
    output logic                    out_valid,
    output logic                    out_last
);

    // stage 1 state, the stage 2 state is out_valid and out_last
    logic valid_s1;
    logic last_s1;

    // a beat enters only when every channel offers one in the same cycle
    logic accept;

    // the whole pipe moves as one, unless the output holds a beat the sink refuses
    // an empty stage 1 still moves, bubbles are not squeezed out
    assign advance = !out_valid || out_ready;

    // input ready is the advance condition itself
    assign in_ready = advance;

    assign accept = in_ready && (&in_valid);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_s1 <= 1'b0;
            last_s1 <= 1'b0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else if (advance) begin
            // stage 1 picks up the acceptance, stage 2 takes what stage 1 held
            valid_s1 <= accept;
            last_s1 <= accept && in_last;
            out_valid <= valid_s1;
            out_last <= last_s1;
        end
    end

endmodule

`default_nettype wire

//--- tests/beam_sum_cases.txt
# D name last wr0 wi0 wr1 wi1 wr2 wi2 wr3 wi3 re0 im0 re1 im1 re2 im2 re3 im3 exp_re exp_im
# R name beats stall_percent  (all D fields hex, lane 0 in the low byte of a word)
# weight 0.5 on every channel, lane 0 at +-100, lane 1 rounds half values up
D d_half 1 40 00 40 00 40 00 40 00 0164 039c 0164 039c 0164 039c 0164 039c 0132 02ce
# weight -0.5 on every channel
D d_neg_half 0 c0 00 c0 00 c0 00 c0 00 0164 039c 0164 039c 0164 039c 0164 039c 00ce ff32
# pure imaginary weight j0.5
D d_imag 1 00 40 00 40 00 40 00 40 0164 039c 0164 039c 0164 039c 0164 039c ff32 0132
# -1 times -128 saturates to +127 in every channel
D d_sat 0 80 00 80 00 80 00 80 00 80 00 80 00 80 00 80 00 7f 00
# one channel only, the sum of 2 averages to 0.5 and rounds up to 1
D d_round 1 7f 00 00 00 00 00 00 00 02 00 00 00 00 00 00 00 01 00
# weight 0.5+j0.5 on channel 0 only
D d_cross 0 40 40 00 00 00 00 00 00 20 10 00 00 00 00 00 00 02 06
# all zero
D d_zero 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
# random streams, the sink stalls for the given share of cycles
R r_stream 200 0
R r_backpressure 200 30
R r_heavy_stall 100 70
R r_short 5 50
# directed again after stalls, to see the pipe has recovered
D d_half_again 0 40 00 40 00 40 00 40 00 0164 039c 0164 039c 0164 039c 0164 039c 0132 02ce
R r_tail 40 0

//--- tests/beam_sum_checker.sv
//********************
// protocol assertions on the top level output
// stream, attached to every beam_sum_top by bind
//********************
`timescale 1ns/1ns
`default_nettype none

module beam_sum_checker
    import beam_pkg::*;
(
    input wire logic  clock,
    input wire logic  resetn,
    input wire logic  s_ready,
    input wire logic  m_valid,
    input wire beat_t m_real,
    input wire beat_t m_imag,
    input wire logic  m_last,
    input wire logic  m_ready
);

    // the output stream is empty on the edge after any reset edge
    a_reset_empty: assert property (@(posedge clock) !resetn |=> !m_valid)
        else $error("m_valid is high right after a reset cycle");

    // a refused beat stays on the bus unchanged until the sink takes it
    a_stall_hold: assert property (@(posedge clock) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_real) && $stable(m_imag)
            && $stable(m_last))
        else $error("output beat changed while the sink stalled");

    // the shared input ready is the pipeline advance condition
    a_ready_rule: assert property (@(posedge clock) disable iff (!resetn)
        s_ready == (!m_valid || m_ready))
        else $error("s_ready differs from the advance condition");

endmodule

bind beam_sum_top beam_sum_checker i_checker (
    .clock(clock),
    .resetn(resetn),
    .s_ready(s_ready),
    .m_valid(m_valid),
    .m_real(m_real),
    .m_imag(m_imag),
    .m_last(m_last),
    .m_ready(m_ready)
);

`default_nettype wire

//--- tests/beam_sum_tb.sv
//********************
// testbench for beam_sum_top with case file reader,
// drivers, reference model, compare tasks and watchdog
//********************
`timescale 1ns/1ns
`default_nettype none

module beam_sum_tb
    import beam_pkg::*;
;

    localparam int CLOCK_PERIOD = 10;
    localparam int MAX_CASES = 64;

    logic clock;
    logic resetn;
    logic s_valid [NUM_CHANNELS];
    beat_t s_real [NUM_CHANNELS];
    beat_t s_imag [NUM_CHANNELS];
    logic s_last [NUM_CHANNELS];
    weight_t w_re [NUM_CHANNELS];
    weight_t w_im [NUM_CHANNELS];
    logic s_ready;
    logic m_valid;
    beat_t m_real;
    beat_t m_imag;
    logic m_last;
    logic m_ready;

    // cases as read from the file with weights and words in channel order re then im
    string case_kind [MAX_CASES];
    string case_name [MAX_CASES];
    logic case_last [MAX_CASES];
    weight_t case_w [MAX_CASES][8];
    beat_t case_word [MAX_CASES][8];
    beat_t case_exp [MAX_CASES][2];
    int case_beats [MAX_CASES];
    int case_stall [MAX_CASES];
    int num_cases = 0;
    int total_beats = 0;
    int limit_cycles = 0;

    // state of the case now running that the monitor reads at acceptance
    string current_name = "reset";
    bit directed_mode = 1'b0;
    int current_stall = 0;
    int current_case = 0;

    // expected beats in acceptance order
    beat_t exp_real_q [$];
    beat_t exp_imag_q [$];
    logic exp_last_q [$];
    string exp_name_q [$];
    int exp_cycle_q [$];
    bit exp_timed_q [$];

    int cycle_count = 0;
    int accept_count = 0;
    int output_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    logic [31:0] lfsr_state = 32'h7213;

    beam_sum_top #(.lanes(DEFAULT_LANES)) i_dut (
        .clock(clock), .resetn(resetn),
        .s_valid_0(s_valid[0]), .s_real_0(s_real[0]), .s_imag_0(s_imag[0]),
        .s_last_0(s_last[0]), .weight_real_0(w_re[0]), .weight_imag_0(w_im[0]),
        .s_valid_1(s_valid[1]), .s_real_1(s_real[1]), .s_imag_1(s_imag[1]),
        .s_last_1(s_last[1]), .weight_real_1(w_re[1]), .weight_imag_1(w_im[1]),
        .s_valid_2(s_valid[2]), .s_real_2(s_real[2]), .s_imag_2(s_imag[2]),
        .s_last_2(s_last[2]), .weight_real_2(w_re[2]), .weight_imag_2(w_im[2]),
        .s_valid_3(s_valid[3]), .s_real_3(s_real[3]), .s_imag_3(s_imag[3]),
        .s_last_3(s_last[3]), .weight_real_3(w_re[3]), .weight_imag_3(w_im[3]),
        .s_ready(s_ready),
        .m_valid(m_valid), .m_real(m_real), .m_imag(m_imag), .m_last(m_last),
        .m_ready(m_ready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic beat_t random_beat();
        beat_t word;
        for (int i = 0; i < $bits(beat_t) / 32; i++) begin
            word[i*32 +: 32] = random_bits(32);
        end
        return word;
    endfunction

    function automatic bit all_valid();
        bit all;
        all = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            all = all && (s_valid[c] === 1'b1);
        end
        return all;
    endfunction

    // one weighted sample is the complex product rounded half up by 64, shifted by 7 and clamped
    function automatic int weigh_lane(input sample_t sr, input sample_t si,
                                      input weight_t wr, input weight_t wi,
                                      input bit imag_part);
        int p;
        if (imag_part) begin
            p = int'(wr) * int'(si) + int'(wi) * int'(sr);
        end else begin
            p = int'(wr) * int'(sr) - int'(wi) * int'(si);
        end
        p = (p + 64) >>> 7;
        if (p > 127) begin
            p = 127;
        end else if (p < -128) begin
            p = -128;
        end
        return p;
    endfunction

    // expected output word from the inputs now on the ports
    function automatic beat_t model_beat(input bit imag_part);
        beat_t word;
        int sum;
        sample_t sr;
        sample_t si;
        word = '0;
        for (int l = 0; l < DEFAULT_LANES; l++) begin
            sum = 0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                sr = s_real[c][l*SAMPLE_WIDTH +: SAMPLE_WIDTH];
                si = s_imag[c][l*SAMPLE_WIDTH +: SAMPLE_WIDTH];
                sum = sum + weigh_lane(sr, si, w_re[c], w_im[c], imag_part);
            end
            // average of four that rounds half up
            sum = (sum + 2) >>> 2;
            word[l*SAMPLE_WIDTH +: SAMPLE_WIDTH] = 8'(sum);
        end
        return word;
    endfunction

    task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // one process watches both sides, so pops and pushes keep a fixed order
    always @(posedge clock) begin : monitor
        int latency;
        if (resetn === 1'b1) begin
            if (m_valid === 1'b1 && m_ready === 1'b1) begin
                output_count++;
                if (exp_real_q.size() == 0) begin
                    other_errors++;
                    $display("an output beat came out with no accepted input beat");
                end else begin
                    check_beat({exp_name_q[0], " real"}, exp_real_q.pop_front(), m_real);
                    check_beat({exp_name_q[0], " imag"}, exp_imag_q.pop_front(), m_imag);
                    check_flag({exp_name_q[0], " last"}, exp_last_q.pop_front(), m_last);
                    latency = cycle_count - exp_cycle_q.pop_front();
                    if (exp_timed_q.pop_front() && latency != 2) begin
                        other_errors++;
                        $display("beat of %s came out %0d cycles after acceptance, not 2",
                                 exp_name_q[0], latency);
                    end
                    void'(exp_name_q.pop_front());
                end
            end
            if (s_ready === 1'b1 && all_valid()) begin
                accept_count++;
                if (directed_mode) begin
                    exp_real_q.push_back(case_exp[current_case][0]);
                    exp_imag_q.push_back(case_exp[current_case][1]);
                end else begin
                    exp_real_q.push_back(model_beat(1'b0));
                    exp_imag_q.push_back(model_beat(1'b1));
                end
                exp_last_q.push_back(s_last[0]);
                exp_name_q.push_back(current_name);
                exp_cycle_q.push_back(cycle_count);
                exp_timed_q.push_back(current_stall == 0);
            end
        end
        cycle_count++;
    end

    task automatic read_cases();
        int fd;
        int n;
        string line;
        string kind;
        string name;
        fd = $fopen("tests/beam_sum_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the case file tests/beam_sum_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s", kind, name);
                if (n < 2 || kind.getc(0) == "#" || num_cases >= MAX_CASES) begin
                    continue;
                end
                case_kind[num_cases] = kind;
                case_name[num_cases] = name;
                if (kind == "D") begin
                    n = $sscanf(line,
                        "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        kind, name, case_last[num_cases],
                        case_w[num_cases][0], case_w[num_cases][1], case_w[num_cases][2],
                        case_w[num_cases][3], case_w[num_cases][4], case_w[num_cases][5],
                        case_w[num_cases][6], case_w[num_cases][7],
                        case_word[num_cases][0], case_word[num_cases][1],
                        case_word[num_cases][2], case_word[num_cases][3],
                        case_word[num_cases][4], case_word[num_cases][5],
                        case_word[num_cases][6], case_word[num_cases][7],
                        case_exp[num_cases][0], case_exp[num_cases][1]);
                    case_beats[num_cases] = 1;
                end else begin
                    n = $sscanf(line, "%s %s %d %d", kind, name,
                                case_beats[num_cases], case_stall[num_cases]);
                end
                total_beats += case_beats[num_cases];
                num_cases++;
            end
            $fclose(fd);
        end
    endtask

    // holds the beat on the inputs until the DUT takes it
    task automatic send_beat(input int stall, input bit gate);
        bit done;
        done = 1'b0;
        while (!done) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                s_valid[c] <= gate ? (random_bits(3) != 0) : 1'b1;
            end
            m_ready <= (stall == 0) || ((random_bits(7) % 100) >= stall);
            @(posedge clock);
            done = (s_ready === 1'b1) && all_valid();
        end
    endtask

    // waits until every accepted beat has left while the sink keeps stalling
    // the beat taken on the calling edge is in the queue by the first check
    task automatic drain(input int stall);
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            s_valid[c] <= 1'b0;
        end
        do begin
            m_ready <= (stall == 0) || ((random_bits(7) % 100) >= stall);
            @(posedge clock);
        end while (exp_real_q.size() != 0);
        m_ready <= 1'b1;
    endtask

    task automatic run_directed(input int k);
        current_case = k;
        current_name = case_name[k];
        directed_mode = 1'b1;
        current_stall = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            w_re[c] <= case_w[k][2*c];
            w_im[c] <= case_w[k][2*c+1];
            s_real[c] <= case_word[k][2*c];
            s_imag[c] <= case_word[k][2*c+1];
            s_last[c] <= (c == 0) ? case_last[k] : 1'b0;
        end
        send_beat(0, 1'b0);
        drain(0);
    endtask

    task automatic run_random(input int k);
        current_case = k;
        current_name = case_name[k];
        directed_mode = 1'b0;
        current_stall = case_stall[k];
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            w_re[c] <= weight_t'(random_bits(8));
            w_im[c] <= weight_t'(random_bits(8));
        end
        for (int b = 0; b < case_beats[k]; b++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                s_real[c] <= random_beat();
                s_imag[c] <= random_beat();
                s_last[c] <= random_bits(1) != 0;
            end
            send_beat(case_stall[k], 1'b1);
        end
        drain(case_stall[k]);
    endtask

    // the run may only last about 20 cycles per beat plus reset and drain
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("timeout after %0d cycles, the DUT stopped delivering beats", limit_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        resetn = 1'b0;
        m_ready = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            s_valid[c] = 1'b0;
            s_real[c] = '0;
            s_imag[c] = '0;
            s_last[c] = 1'b0;
            w_re[c] = '0;
            w_im[c] = '0;
        end
        read_cases();
        limit_cycles = total_beats * 20 + 200;
        repeat (10) @(posedge clock);
        resetn <= 1'b1;
        @(posedge clock);
        check_flag("reset m_valid", 1'b0, m_valid);
        check_flag("reset m_last", 1'b0, m_last);
        check_flag("reset s_ready", 1'b1, s_ready);
        for (int k = 0; k < num_cases; k++) begin
            if (case_kind[k] == "D") begin
                run_directed(k);
            end else begin
                run_random(k);
            end
        end
        repeat (2) @(posedge clock);
        if (accept_count != output_count) begin
            other_errors++;
            $display("%0d beats were accepted but %0d came out", accept_count, output_count);
        end
        $display("errors: %0d wrong values, %0d other failures, %0d beats checked",
                 value_errors, other_errors, output_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
